// ==== aluCtrlDecoder.sv ====
`timescale 1ns/10ps

module aluCtrlDecoder (
    input  logic                               isBranch,
    input  logic                               isOpImm,
    input  logic                               isOp,
    input  logic [rvIsaPkg::FUNCT3_W-1:0]      funct3,
    input  logic [rvIsaPkg::FUNCT7_W-1:0]      funct7,
    output logic [decodeCtrlPkg::ALU_OP_W-1:0] aluOp,
    output logic [decodeCtrlPkg::CMP_W-1:0]    cmpType,
    output logic                               condSet
);
    import rvIsaPkg::*;
    import decodeCtrlPkg::*;

    logic isArith; // op or op-imm
    logic isSub;

    assign isArith = isOp | isOpImm;
    assign condSet = isArith && ((funct3 == F3_SLT) || (funct3 == F3_SLTU)); // slt(i)(u)

    always_comb begin
        cmpType = CMP_EQ;
        if (isBranch) begin
            case (funct3)
                F3_BNE:  cmpType = CMP_NE;
                F3_BLT:  cmpType = CMP_LT;
                F3_BGE:  cmpType = CMP_GE;
                F3_BLTU: cmpType = CMP_LTU;
                F3_BGEU: cmpType = CMP_GEU;
                default: cmpType = CMP_EQ; // beq and the two reserved codes
            endcase
        end else if (condSet) begin
            cmpType = (funct3 == F3_SLTU) ? CMP_LTU : CMP_LT;
        end
    end

    // compares run through the subtractor, no subi for op-imm
    assign isSub = isBranch | condSet
                 | (isOp && (funct3 == F3_ADD) && (funct7 == F7_ALT));

    always_comb begin
        aluOp = ALU_ADD;
        if (isSub) begin
            aluOp = ALU_SUB;
        end else if (isArith) begin
            case (funct3)
                F3_SLL: begin
                    if (funct7 == F7_BASE) aluOp = ALU_SLL;
                end
                F3_SR: begin
                    if (funct7 == F7_BASE) aluOp = ALU_SRL;
                    else if (funct7 == F7_ALT) aluOp = ALU_SRA;
                end
                F3_XOR:  aluOp = ALU_XOR; // funct7 don't care
                F3_OR:   aluOp = ALU_OR;
                F3_AND:  aluOp = ALU_AND;
                default: aluOp = ALU_ADD; // add/addi
            endcase
        end
    end

endmodule

// ==== datapathSelDecoder.sv ====
`timescale 1ns/10ps

module datapathSelDecoder (
    input  logic                              isLui,
    input  logic                              isAuipc,
    input  logic                              isJal,
    input  logic                              isJalr,
    input  logic                              isBranch,
    input  logic                              isLoad,
    input  logic                              isStore,
    input  logic                              isOpImm,
    input  logic                              isOp,
    input  logic                              isSystem,
    input  logic                              isEbreak,
    input  logic                              isEcall,
    input  logic                              isMret,
    input  logic                              isIllegal,
    input  logic                              condSet,
    output logic [decodeCtrlPkg::WB_W-1:0]    rdRegSrc,
    output logic [decodeCtrlPkg::SRC1_W-1:0]  aluSrc1,
    output logic [decodeCtrlPkg::SRC2_W-1:0]  aluSrc2,
    output logic [decodeCtrlPkg::ITYPE_W-1:0] instType,
    output logic                              jump,
    output logic                              stopSim,
    output logic                              writeCsr
);
    import decodeCtrlPkg::*;

    logic rdDisable; // no rd write for these

    assign jump      = isJal | isJalr;
    assign stopSim   = isEbreak | isIllegal; // halt the sim on ebreak or bad word
    assign writeCsr  = isSystem | isEcall;
    assign rdDisable = isBranch | isStore | isEcall | isMret | isEbreak | isIllegal;

    // disable wins over csr so ecall/mret never write rd
    always_comb begin
        if (isLoad)         rdRegSrc = WB_MEM;
        else if (jump)      rdRegSrc = WB_SNPC; // link address
        else if (condSet)   rdRegSrc = WB_CMP;
        else if (rdDisable) rdRegSrc = WB_NONE;
        else if (isSystem)  rdRegSrc = WB_CSR; // old csr value
        else                rdRegSrc = WB_ALU;
    end

    assign aluSrc1 = isAuipc ? S1_PC : S1_RS1;
    assign aluSrc2 = isOp ? S2_RS2 : (isSystem ? S2_CSR : S2_IMM);

    always_comb begin
        if (isLui || isAuipc)                  instType = IT_U;
        else if (isJal)                        instType = IT_J;
        else if (isJalr || isLoad || isOpImm)  instType = IT_I;
        else if (isStore)                      instType = IT_S;
        else if (isOp)                         instType = IT_R;
        else if (isBranch)                     instType = IT_B;
        else                                   instType = IT_N; // system, illegal
    end

endmodule

// ==== decodeCtrlPkg.sv ====
package decodeCtrlPkg;

    // alu operation
    localparam int ALU_OP_W = 3;
    localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1; // also used for compares
    localparam logic [ALU_OP_W-1:0] ALU_SRA = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SLL = 3'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRL = 3'd7;

    // compare unit
    localparam int CMP_W = 3;
    localparam logic [CMP_W-1:0] CMP_EQ  = 3'd0;
    localparam logic [CMP_W-1:0] CMP_NE  = 3'd1;
    localparam logic [CMP_W-1:0] CMP_LT  = 3'd2;
    localparam logic [CMP_W-1:0] CMP_GE  = 3'd3;
    localparam logic [CMP_W-1:0] CMP_LTU = 3'd4;
    localparam logic [CMP_W-1:0] CMP_GEU = 3'd5; // highest legal code

    // memory read type
    localparam int MRTYPE_W = 3;
    localparam logic [MRTYPE_W-1:0] MR_B  = 3'd0;
    localparam logic [MRTYPE_W-1:0] MR_H  = 3'd1;
    localparam logic [MRTYPE_W-1:0] MR_W  = 3'd2;
    localparam logic [MRTYPE_W-1:0] MR_BU = 3'd3;
    localparam logic [MRTYPE_W-1:0] MR_HU = 3'd4;

    // byte write mask
    localparam int WMASK_W = 8;
    localparam logic [WMASK_W-1:0] WM_NONE = 8'h00;
    localparam logic [WMASK_W-1:0] WM_B    = 8'h01;
    localparam logic [WMASK_W-1:0] WM_H    = 8'h03;
    localparam logic [WMASK_W-1:0] WM_W    = 8'h0F;

    // rd writeback source
    localparam int WB_W = 3;
    localparam logic [WB_W-1:0] WB_ALU  = 3'd0;
    localparam logic [WB_W-1:0] WB_MEM  = 3'd1;
    localparam logic [WB_W-1:0] WB_SNPC = 3'd2; // pc + 4
    localparam logic [WB_W-1:0] WB_CMP  = 3'd3;
    localparam logic [WB_W-1:0] WB_CSR  = 3'd4;
    localparam logic [WB_W-1:0] WB_NONE = 3'd5; // no rd write

    localparam int SRC1_W = 3;
    localparam logic [SRC1_W-1:0] S1_RS1 = 3'd0;
    localparam logic [SRC1_W-1:0] S1_PC  = 3'd1;

    localparam int SRC2_W = 2;
    localparam logic [SRC2_W-1:0] S2_RS2 = 2'd0;
    localparam logic [SRC2_W-1:0] S2_IMM = 2'd1;
    localparam logic [SRC2_W-1:0] S2_CSR = 2'd2;

    // instruction format, selects immediate layout downstream
    localparam int ITYPE_W = 3;
    localparam logic [ITYPE_W-1:0] IT_I = 3'd0;
    localparam logic [ITYPE_W-1:0] IT_S = 3'd1;
    localparam logic [ITYPE_W-1:0] IT_R = 3'd2;
    localparam logic [ITYPE_W-1:0] IT_U = 3'd3;
    localparam logic [ITYPE_W-1:0] IT_J = 3'd4;
    localparam logic [ITYPE_W-1:0] IT_B = 3'd5;
    localparam logic [ITYPE_W-1:0] IT_N = 3'd6; // no immediate

endpackage

// ==== idu.f ====
rvIsaPkg.sv
decodeCtrlPkg.sv
instClassDecoder.sv
memCtrlDecoder.sv
aluCtrlDecoder.sv
datapathSelDecoder.sv
idu.sv
tbIdu.sv

// ==== idu.sv ====
`timescale 1ns/10ps

module idu (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               inValid,
    input  logic [rvIsaPkg::XLEN-1:0]          instr,
    output logic                               outValid,
    output logic                               memValid,
    output logic                               memWen,
    output logic [decodeCtrlPkg::WMASK_W-1:0]  memWmask,
    output logic [decodeCtrlPkg::MRTYPE_W-1:0] memRtype,
    output logic [decodeCtrlPkg::CMP_W-1:0]    cmpType,
    output logic                               branch,
    output logic                               jump,
    output logic [decodeCtrlPkg::ALU_OP_W-1:0] aluOp,
    output logic [decodeCtrlPkg::WB_W-1:0]     rdRegSrc,
    output logic                               jalr,
    output logic [decodeCtrlPkg::SRC1_W-1:0]   aluSrc1,
    output logic [decodeCtrlPkg::SRC2_W-1:0]   aluSrc2,
    output logic [decodeCtrlPkg::ITYPE_W-1:0]  instType,
    output logic                               ecall,
    output logic                               mret,
    output logic                               writeCsr,
    output logic                               stopSim
);
    import decodeCtrlPkg::*;

    logic [rvIsaPkg::FUNCT3_W-1:0] funct3;
    logic [rvIsaPkg::FUNCT7_W-1:0] funct7;
    logic isLui, isAuipc, isJal, isJalr, isBranch, isLoad, isStore;
    logic isOpImm, isOp, isSystem, isEbreak, isEcall, isMret, isIllegal;
    logic condSet;

    // decode-stage controls, comb
    logic                memValidD, memWenD, jumpD, stopSimD, writeCsrD;
    logic [WMASK_W-1:0]  memWmaskD;
    logic [MRTYPE_W-1:0] memRtypeD;
    logic [CMP_W-1:0]    cmpTypeD;
    logic [ALU_OP_W-1:0] aluOpD;
    logic [WB_W-1:0]     rdRegSrcD;
    logic [SRC1_W-1:0]   aluSrc1D;
    logic [SRC2_W-1:0]   aluSrc2D;
    logic [ITYPE_W-1:0]  instTypeD;

    instClassDecoder u_class (
        .instr, .funct3, .funct7, .isLui, .isAuipc, .isJal, .isJalr, .isBranch,
        .isLoad, .isStore, .isOpImm, .isOp, .isSystem, .isEbreak, .isEcall,
        .isMret, .isIllegal
    );

    memCtrlDecoder u_mem (
        .isLoad, .isStore, .funct3, .memValid(memValidD), .memWen(memWenD),
        .memWmask(memWmaskD), .memRtype(memRtypeD)
    );

    aluCtrlDecoder u_alu (
        .isBranch, .isOpImm, .isOp, .funct3, .funct7, .aluOp(aluOpD),
        .cmpType(cmpTypeD), .condSet
    );

    datapathSelDecoder u_sel (
        .isLui, .isAuipc, .isJal, .isJalr, .isBranch, .isLoad, .isStore, .isOpImm,
        .isOp, .isSystem, .isEbreak, .isEcall, .isMret, .isIllegal, .condSet,
        .rdRegSrc(rdRegSrcD), .aluSrc1(aluSrc1D), .aluSrc2(aluSrc2D),
        .instType(instTypeD), .jump(jumpD), .stopSim(stopSimD), .writeCsr(writeCsrD)
    );

    // decode/execute boundary, holds on idle cycles
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
            memValid <= 1'b0;
            memWen   <= 1'b0;
            memWmask <= '0;
            memRtype <= '0;
            cmpType  <= '0;
            branch   <= 1'b0;
            jump     <= 1'b0;
            aluOp    <= '0;
            rdRegSrc <= '0;
            jalr     <= 1'b0;
            aluSrc1  <= '0;
            aluSrc2  <= '0;
            instType <= '0;
            ecall    <= 1'b0;
            mret     <= 1'b0;
            writeCsr <= 1'b0;
            stopSim  <= 1'b0;
        end else begin
            outValid <= inValid; // one-cycle pulse per accepted word
            if (inValid) begin
                memValid <= memValidD;
                memWen   <= memWenD;
                memWmask <= memWmaskD;
                memRtype <= memRtypeD;
                cmpType  <= cmpTypeD;
                branch   <= isBranch; // raw class flag
                jump     <= jumpD;
                aluOp    <= aluOpD;
                rdRegSrc <= rdRegSrcD;
                jalr     <= isJalr;
                aluSrc1  <= aluSrc1D;
                aluSrc2  <= aluSrc2D;
                instType <= instTypeD;
                ecall    <= isEcall;
                mret     <= isMret;
                writeCsr <= writeCsrD;
                stopSim  <= stopSimD;
            end
        end
    end

    outValidKnown: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown(outValid));
    wenNeedsAccess: assert property (@(posedge clk) disable iff (!rstN)
        memWen |-> memValid); // store class must also set access
    stopNoWrite: assert property (@(posedge clk) disable iff (!rstN)
        stopSim |-> rdRegSrc == WB_NONE); // ebreak/illegal never write rd
    cmpInRange: assert property (@(posedge clk) disable iff (!rstN)
        cmpType <= CMP_GEU);

endmodule

// ==== instClassDecoder.sv ====
`timescale 1ns/10ps

module instClassDecoder (
    input  logic [rvIsaPkg::XLEN-1:0]     instr,
    output logic [rvIsaPkg::FUNCT3_W-1:0] funct3,
    output logic [rvIsaPkg::FUNCT7_W-1:0] funct7,
    output logic                          isLui,
    output logic                          isAuipc,
    output logic                          isJal,
    output logic                          isJalr,
    output logic                          isBranch,
    output logic                          isLoad,
    output logic                          isStore,
    output logic                          isOpImm,
    output logic                          isOp,
    output logic                          isSystem,
    output logic                          isEbreak,
    output logic                          isEcall,
    output logic                          isMret,
    output logic                          isIllegal
);
    import rvIsaPkg::*;

    logic [OPCODE_W-1:0]  opcode;
    logic [FUNCT12_W-1:0] funct12;
    logic                 sysPriv; // system opcode with funct3 000

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign funct12 = instr[31:20]; // overlaps funct7 + rs2

    assign isLui    = opcode == OP_LUI;
    assign isAuipc  = opcode == OP_AUIPC;
    assign isJal    = opcode == OP_JAL;
    assign isJalr   = (opcode == OP_JALR) && (funct3 == 3'b000); // nonzero funct3 is illegal
    assign isBranch = opcode == OP_BRANCH;
    assign isLoad   = opcode == OP_LOAD;
    assign isStore  = opcode == OP_STORE;
    assign isOpImm  = opcode == OP_IMM;
    assign isOp     = opcode == OP_REG;
    assign isSystem = opcode == OP_SYSTEM; // csr ops and the priv ones

    assign sysPriv  = isSystem && (funct3 == 3'b000);
    assign isEbreak = sysPriv && (funct12 == F12_EBREAK);
    assign isEcall  = sysPriv && (funct12 == F12_ECALL);
    assign isMret   = sysPriv && (funct12 == F12_MRET);

    // priv flags are a subset of isSystem, so they add nothing here
    assign isIllegal = ~(isLui | isAuipc | isJal | isJalr | isBranch | isLoad
                       | isStore | isOpImm | isOp | isSystem);

endmodule

// ==== memCtrlDecoder.sv ====
`timescale 1ns/10ps

module memCtrlDecoder (
    input  logic                               isLoad,
    input  logic                               isStore,
    input  logic [rvIsaPkg::FUNCT3_W-1:0]      funct3,
    output logic                               memValid,
    output logic                               memWen,
    output logic [decodeCtrlPkg::WMASK_W-1:0]  memWmask,
    output logic [decodeCtrlPkg::MRTYPE_W-1:0] memRtype
);
    import rvIsaPkg::*;
    import decodeCtrlPkg::*;

    assign memValid = isLoad | isStore;
    assign memWen   = isStore;

    // mask and read type from funct3 only, qualified later by memValid/memWen
    always_comb begin
        case (funct3)
            F3_B:    memWmask = WM_B;
            F3_H:    memWmask = WM_H;
            F3_W:    memWmask = WM_W;
            default: memWmask = WM_NONE; // bu/hu have no store form
        endcase
    end

    always_comb begin
        case (funct3)
            F3_B:    memRtype = MR_B;
            F3_H:    memRtype = MR_H;
            F3_W:    memRtype = MR_W;
            F3_BU:   memRtype = MR_BU;
            F3_HU:   memRtype = MR_HU;
            default: memRtype = MR_B;
        endcase
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the idu testbench with Verilator; sim.log decides the result
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tbIdu -f idu.f > sim.log 2>&1 &&
    ./obj_dir/VtbIdu >> sim.log 2>&1 ||
    echo "*** TEST FAILED ***" >> sim.log
grep -qF "*** TEST FAILED ***" sim.log && { echo "FAIL, see sim.log"; exit 1; } ||
    { echo "PASS"; exit 0; }

// ==== rvIsaPkg.sv ====
package rvIsaPkg;

    localparam int XLEN      = 32;
    localparam int OPCODE_W  = 7;
    localparam int FUNCT3_W  = 3;
    localparam int FUNCT7_W  = 7;
    localparam int FUNCT12_W = 12;

    // major opcodes, inst[6:0]
    localparam logic [OPCODE_W-1:0] OP_LUI    = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OP_AUIPC  = 7'b0010111;
    localparam logic [OPCODE_W-1:0] OP_JAL    = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OP_JALR   = 7'b1100111;
    localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OP_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OP_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OP_IMM    = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OP_REG    = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OP_SYSTEM = 7'b1110011;

    // branch funct3
    localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

    // arith funct3, shared by op and op-imm
    localparam logic [FUNCT3_W-1:0] F3_ADD  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLL  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT  = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SLTU = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_XOR  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SR   = 3'b101; // srl / sra split by funct7
    localparam logic [FUNCT3_W-1:0] F3_OR   = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND  = 3'b111;

    // load/store size funct3
    localparam logic [FUNCT3_W-1:0] F3_B  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_H  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_W  = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_BU = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_HU = 3'b101;

    localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000; // sub, sra

    localparam logic [FUNCT12_W-1:0] F12_ECALL  = 12'h000;
    localparam logic [FUNCT12_W-1:0] F12_EBREAK = 12'h001;
    localparam logic [FUNCT12_W-1:0] F12_MRET   = 12'h302;

endpackage

// ==== tbIdu.sv ====
`timescale 1ns/10ps

module tbIdu;
    import rvIsaPkg::*;
    import decodeCtrlPkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int NUM_CYCLES   = 2000;
    localparam int MAX_CYCLES   = 2100; // reset + stimulus + drain, with margin

    // expected control record, one field per DUT output
    typedef struct packed {
        logic                memValid;
        logic                memWen;
        logic [WMASK_W-1:0]  memWmask;
        logic [MRTYPE_W-1:0] memRtype;
        logic [CMP_W-1:0]    cmpType;
        logic                branch;
        logic                jump;
        logic [ALU_OP_W-1:0] aluOp;
        logic [WB_W-1:0]     rdRegSrc;
        logic                jalr;
        logic [SRC1_W-1:0]   aluSrc1;
        logic [SRC2_W-1:0]   aluSrc2;
        logic [ITYPE_W-1:0]  instType;
        logic                ecall;
        logic                mret;
        logic                writeCsr;
        logic                stopSim;
    } ctrlRecT;

    logic clk = 1'b0;
    logic rstN, inValid;
    logic [XLEN-1:0] instr;
    logic outValid, memValid, memWen, branch, jump, jalr, ecall, mret, writeCsr, stopSim;
    logic [WMASK_W-1:0]  memWmask;
    logic [MRTYPE_W-1:0] memRtype;
    logic [CMP_W-1:0]    cmpType;
    logic [ALU_OP_W-1:0] aluOp;
    logic [WB_W-1:0]     rdRegSrc;
    logic [SRC1_W-1:0]   aluSrc1;
    logic [SRC2_W-1:0]   aluSrc2;
    logic [ITYPE_W-1:0]  instType;

    int      seed = 32'h7711;
    int      cycleCnt = 0;
    int      errCnt = 0;
    int      checkCnt = 0;
    logic    expVld = 1'b0; // outValid expected after the next edge
    ctrlRecT expRec = '0;   // holds across idle cycles

    idu u_dut (
        .clk, .rstN, .inValid, .instr, .outValid, .memValid, .memWen, .memWmask,
        .memRtype, .cmpType, .branch, .jump, .aluOp, .rdRegSrc, .jalr, .aluSrc1,
        .aluSrc2, .instType, .ecall, .mret, .writeCsr, .stopSim
    );

    always #5 clk = ~clk; // 10 ns period

    task automatic checkVal(string name, logic [31:0] act, logic [31:0] exp);
        checkCnt++;
        if (act !== exp) begin
            errCnt++;
            $display("[ERROR] %0t %s: got %0h expected %0h", $time, name, act, exp);
        end
    endtask

    function automatic logic [OPCODE_W-1:0] legalOpcode(int unsigned idx);
        case (idx)
            0:       return OP_LUI;
            1:       return OP_AUIPC;
            2:       return OP_JAL;
            3:       return OP_JALR;
            4:       return OP_BRANCH;
            5:       return OP_LOAD;
            6:       return OP_STORE;
            7:       return OP_IMM;
            8:       return OP_REG;
            default: return OP_SYSTEM;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] randomInstr();
        logic [XLEN-1:0] word;
        int unsigned     pick;
        word = $random(seed);
        pick = {$random(seed)} % 100;
        if (pick < 15) return word; // fully random, mostly illegal opcodes
        word[6:0] = legalOpcode({$random(seed)} % 10);
        pick = {$random(seed)} % 4;
        if (pick == 0) word[31:25] = F7_BASE;
        else if (pick == 1) word[31:25] = F7_ALT; // sub, sra
        if (word[6:0] == OP_SYSTEM || word[6:0] == OP_JALR) begin
            if ({$random(seed)} % 2 == 0) word[14:12] = 3'b000;
        end
        if (word[6:0] == OP_SYSTEM) begin
            pick = {$random(seed)} % 4;
            if (pick == 0) word[31:20] = F12_ECALL;
            else if (pick == 1) word[31:20] = F12_EBREAK;
            else if (pick == 2) word[31:20] = F12_MRET;
        end
        return word;
    endfunction

    function automatic logic [ALU_OP_W-1:0] arithOp(logic [2:0] f3, logic [6:0] f7,
                                                    logic isReg);
        case (f3)
            F3_ADD:  return (isReg && f7 == F7_ALT) ? ALU_SUB : ALU_ADD; // no subi
            F3_SLL:  return (f7 == F7_BASE) ? ALU_SLL : ALU_ADD;
            F3_SR:   return (f7 == F7_BASE) ? ALU_SRL : ((f7 == F7_ALT) ? ALU_SRA : ALU_ADD);
            F3_XOR:  return ALU_XOR;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD; // slt/sltu handled by caller
        endcase
    endfunction

    function automatic ctrlRecT refDecode(logic [XLEN-1:0] word);
        ctrlRecT    r;
        logic [6:0] opc;
        logic [2:0] f3;
        logic       illegal;
        opc     = word[6:0];
        f3      = word[14:12];
        illegal = 1'b0;
        r          = '0;
        r.aluSrc2  = S2_IMM;
        r.instType = IT_N;
        case (opc)
            OP_LUI:   r.instType = IT_U;
            OP_AUIPC: begin
                r.instType = IT_U;
                r.aluSrc1  = S1_PC;
            end
            OP_JAL: begin
                r.instType = IT_J;
                r.jump     = 1'b1;
                r.rdRegSrc = WB_SNPC;
            end
            OP_JALR: begin
                if (f3 == 3'b000) begin
                    r.instType = IT_I;
                    r.jump     = 1'b1;
                    r.jalr     = 1'b1;
                    r.rdRegSrc = WB_SNPC;
                end else begin
                    illegal = 1'b1; // reserved funct3
                end
            end
            OP_BRANCH: begin
                r.instType = IT_B;
                r.branch   = 1'b1;
                r.aluOp    = ALU_SUB;
                r.rdRegSrc = WB_NONE;
                case (f3)
                    F3_BNE:  r.cmpType = CMP_NE;
                    F3_BLT:  r.cmpType = CMP_LT;
                    F3_BGE:  r.cmpType = CMP_GE;
                    F3_BLTU: r.cmpType = CMP_LTU;
                    F3_BGEU: r.cmpType = CMP_GEU;
                    default: r.cmpType = CMP_EQ;
                endcase
            end
            OP_LOAD: begin
                r.instType = IT_I;
                r.memValid = 1'b1;
                r.rdRegSrc = WB_MEM;
            end
            OP_STORE: begin
                r.instType = IT_S;
                r.memValid = 1'b1;
                r.memWen   = 1'b1;
                r.rdRegSrc = WB_NONE;
            end
            OP_IMM, OP_REG: begin
                r.instType = (opc == OP_REG) ? IT_R : IT_I;
                r.aluSrc2  = (opc == OP_REG) ? S2_RS2 : S2_IMM;
                r.aluOp    = arithOp(f3, word[31:25], opc == OP_REG);
                if (f3 == F3_SLT || f3 == F3_SLTU) begin
                    r.cmpType  = (f3 == F3_SLT) ? CMP_LT : CMP_LTU;
                    r.aluOp    = ALU_SUB;
                    r.rdRegSrc = WB_CMP;
                end
            end
            OP_SYSTEM: begin
                r.aluSrc2  = S2_CSR;
                r.writeCsr = 1'b1;
                r.rdRegSrc = WB_CSR;
                if (f3 == 3'b000) begin
                    case (word[31:20])
                        F12_ECALL:  r.ecall = 1'b1;
                        F12_EBREAK: r.stopSim = 1'b1;
                        F12_MRET:   r.mret = 1'b1;
                        default:    ;
                    endcase
                    if (r.ecall || r.stopSim || r.mret) r.rdRegSrc = WB_NONE;
                end
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            r.stopSim  = 1'b1;
            r.rdRegSrc = WB_NONE;
        end
        // size fields come from funct3 for every class
        case (f3)
            F3_B:    r.memWmask = WM_B;
            F3_H:    r.memWmask = WM_H;
            F3_W:    r.memWmask = WM_W;
            default: r.memWmask = WM_NONE;
        endcase
        case (f3)
            F3_H:    r.memRtype = MR_H;
            F3_W:    r.memRtype = MR_W;
            F3_BU:   r.memRtype = MR_BU;
            F3_HU:   r.memRtype = MR_HU;
            default: r.memRtype = MR_B;
        endcase
        return r;
    endfunction

    // compare mid-cycle, then predict from the inputs the next edge will sample
    always @(negedge clk) begin
        if (cycleCnt > 0) begin
            checkVal("outValid", 32'(outValid), 32'(expVld));
            checkVal("memValid", 32'(memValid), 32'(expRec.memValid));
            checkVal("memWen", 32'(memWen), 32'(expRec.memWen));
            checkVal("memWmask", 32'(memWmask), 32'(expRec.memWmask));
            checkVal("memRtype", 32'(memRtype), 32'(expRec.memRtype));
            checkVal("cmpType", 32'(cmpType), 32'(expRec.cmpType));
            checkVal("branch", 32'(branch), 32'(expRec.branch));
            checkVal("jump", 32'(jump), 32'(expRec.jump));
            checkVal("aluOp", 32'(aluOp), 32'(expRec.aluOp));
            checkVal("rdRegSrc", 32'(rdRegSrc), 32'(expRec.rdRegSrc));
            checkVal("jalr", 32'(jalr), 32'(expRec.jalr));
            checkVal("aluSrc1", 32'(aluSrc1), 32'(expRec.aluSrc1));
            checkVal("aluSrc2", 32'(aluSrc2), 32'(expRec.aluSrc2));
            checkVal("instType", 32'(instType), 32'(expRec.instType));
            checkVal("ecall", 32'(ecall), 32'(expRec.ecall));
            checkVal("mret", 32'(mret), 32'(expRec.mret));
            checkVal("writeCsr", 32'(writeCsr), 32'(expRec.writeCsr));
            checkVal("stopSim", 32'(stopSim), 32'(expRec.stopSim));
        end
        if (!rstN) begin
            expVld = 1'b0;
            expRec = '0; // register clears
        end else begin
            expVld = inValid;
            if (inValid) expRec = refDecode(instr); // idle cycles hold
        end
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        rstN    = 1'b0;
        inValid = 1'b0;
        instr   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge clk);
            inValid <= ({$random(seed)} % 100) < 80; // ~80% busy
            instr   <= randomInstr();
        end
        @(posedge clk);
        inValid <= 1'b0;
        repeat (2) @(posedge clk); // drain the last word
        $display("checks: %0d, errors: %0d", checkCnt, errCnt);
        if (errCnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
